/* bench/radio_io_tb.sv */
// ==================================================
// radio io testbench
// table-driven DDR rx bus and tx samples, checked
// against a cycle model of both directions
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module radio_io_tb;

  localparam int rst_cycles    = 5;
  localparam int settle_cycles = radio_io_pkg::sync_stages + 4;
  localparam int tail_cycles   = 4;  // drains the last rows through the pipe
  localparam int cat_rx        = 0;
  localparam int cat_tx        = 1;
  localparam int cat_ctl       = 2;

  logic                  radio_clk;
  logic                  radio_rst;
  logic                  mimo_i;
  radio_io_pkg::sample_t rx_data_i;
  logic                  rx_frame_i;
  radio_io_pkg::sample_t rx_i0_o;
  radio_io_pkg::sample_t rx_q0_o;
  radio_io_pkg::sample_t rx_i1_o;
  radio_io_pkg::sample_t rx_q1_o;
  logic                  rx_stb_o;
  radio_io_pkg::sample_t tx_i0_i;
  radio_io_pkg::sample_t tx_q0_i;
  radio_io_pkg::sample_t tx_i1_i;
  radio_io_pkg::sample_t tx_q1_i;
  logic                  tx_stb_o;
  radio_io_pkg::sample_t tx_data_o;
  logic                  tx_frame_o;
  logic                  tx_clk_o;

  // stimulus table, one row per sample pair
  string                 row_name[$];
  bit                    row_mimo[$];
  radio_io_pkg::sample_t row_q[$];   // rising half word
  radio_io_pkg::sample_t row_i[$];   // falling half word
  bit                    row_frame[$];
  radio_io_pkg::sample_t row_i0[$];
  radio_io_pkg::sample_t row_q0[$];
  radio_io_pkg::sample_t row_i1[$];
  radio_io_pkg::sample_t row_q1[$];

  // rows expanded to clock cycles, with settle and drain cycles
  int cyc_row[$];
  bit cyc_chk[$];
  bit cyc_frame[$];

  // reference model state, reset values
  logic                  exp_stb_tx  = 1'b0;
  logic                  exp_ffr     = 1'b0;  // framer frame level
  radio_io_pkg::sample_t exp_fi;
  radio_io_pkg::sample_t exp_fq;
  radio_io_pkg::sample_t exp_di_rise;
  radio_io_pkg::sample_t exp_dq_fall;
  logic                  exp_fr_rise = 1'b0;
  logic                  exp_fr_fall = 1'b0;
  logic                  exp_stb_rx  = 1'b0;
  radio_io_pkg::sample_t exp_i0;
  radio_io_pkg::sample_t exp_q0;
  radio_io_pkg::sample_t exp_i1;
  radio_io_pkg::sample_t exp_q1;

  int err_cnt[3];
  int seed        = 32'hb5e4;
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  radio_io_top u_dut (
    .radio_clk  (radio_clk),
    .radio_rst  (radio_rst),
    .mimo_i     (mimo_i),
    .rx_data_i  (rx_data_i),
    .rx_frame_i (rx_frame_i),
    .rx_i0_o    (rx_i0_o),
    .rx_q0_o    (rx_q0_o),
    .rx_i1_o    (rx_i1_o),
    .rx_q1_o    (rx_q1_o),
    .rx_stb_o   (rx_stb_o),
    .tx_i0_i    (tx_i0_i),
    .tx_q0_i    (tx_q0_i),
    .tx_i1_i    (tx_i1_i),
    .tx_q1_i    (tx_q1_i),
    .tx_stb_o   (tx_stb_o),
    .tx_data_o  (tx_data_o),
    .tx_frame_o (tx_frame_o),
    .tx_clk_o   (tx_clk_o)
  );

  always #2 radio_clk = ~radio_clk;

  always @(posedge radio_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, the stimulus loop never finished", cycle_cnt);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic radio_io_pkg::sample_t rand12();
    int r;
    r = $random(seed);
    return r[radio_io_pkg::sample_w-1:0];
  endfunction

  // mimo level the DUT acts on at edge n, after the synchronizer
  function automatic bit mode_seen(input int n);
    int idx;
    idx = n - 1 - radio_io_pkg::sync_stages;
    if (idx < 0) begin
      return 1'b0;
    end
    return row_mimo[cyc_row[idx]];
  endfunction

  task automatic add_row(input string name, input bit mimo,
                         input radio_io_pkg::sample_t q, input radio_io_pkg::sample_t i,
                         input bit frame,
                         input radio_io_pkg::sample_t i0, input radio_io_pkg::sample_t q0,
                         input radio_io_pkg::sample_t i1, input radio_io_pkg::sample_t q1);
    row_name.push_back(name);
    row_mimo.push_back(mimo);
    row_q.push_back(q);
    row_i.push_back(i);
    row_frame.push_back(frame);
    row_i0.push_back(i0);
    row_q0.push_back(q0);
    row_i1.push_back(i1);
    row_q1.push_back(q1);
  endtask

  task automatic add_random_rows(input bit mode, input int count);
    radio_io_pkg::sample_t w[6];
    radio_io_pkg::sample_t coin;
    bit                    frame;
    for (int k = 0; k < count; k++) begin
      for (int j = 0; j < 6; j++) begin
        w[j] = rand12();
      end
      coin  = rand12();
      frame = mode ? ~k[0] : 1'b1;  // MIMO frame starts high and alternates
      if (!mode && coin[0]) begin
        w[2] = '0;  // idle channel 0 in SISO
        w[3] = '0;
      end
      add_row($sformatf("rand_%s_%0d", mode ? "mimo" : "siso", k), mode,
              w[0], w[1], frame, w[2], w[3], w[4], w[5]);
    end
  endtask

  task automatic fill_table();
    add_row("siso_ch0",      0, 12'h123, 12'h456, 1, 12'h111, 12'h222, 12'h333, 12'h444);
    add_row("siso_ch1",      0, 12'h789, 12'h9ab, 1, 12'h000, 12'h000, 12'habc, 12'hdef);
    add_row("siso_i0_only",  0, 12'hfff, 12'h000, 1, 12'h800, 12'h000, 12'h5a5, 12'ha5a);
    add_row("siso_q0_only",  0, 12'h000, 12'hfff, 1, 12'h000, 12'h001, 12'h3c3, 12'hc3c);
    add_row("siso_idle",     0, 12'h0f0, 12'hf0f, 1, 12'h000, 12'h000, 12'h000, 12'h000);
    add_row("mimo_ch0_a",    1, 12'h101, 12'h202, 1, 12'h0a1, 12'h0a2, 12'h0b1, 12'h0b2);
    add_row("mimo_ch1_a",    1, 12'h303, 12'h404, 0, 12'h0c1, 12'h0c2, 12'h0d1, 12'h0d2);
    add_row("mimo_ch0_b",    1, 12'h505, 12'h606, 1, 12'h7e1, 12'h7e2, 12'h7f1, 12'h7f2);
    add_row("mimo_ch1_b",    1, 12'h707, 12'h808, 0, 12'h000, 12'h000, 12'h001, 12'h002);
    add_row("mimo_ch0_ones", 1, 12'hfff, 12'hfff, 1, 12'hfff, 12'hfff, 12'hfff, 12'hfff);
    add_row("mimo_ch1_zero", 1, 12'h000, 12'h000, 0, 12'h000, 12'h000, 12'h000, 12'h000);
    add_row("siso_back",     0, 12'h2a2, 12'h5d5, 1, 12'h246, 12'h8ac, 12'h135, 12'h79b);
    add_row("siso_back_ch1", 0, 12'hd2d, 12'h4b4, 1, 12'h000, 12'h000, 12'h864, 12'hca8);
    add_random_rows(1'b1, 8);
    add_random_rows(1'b0, 8);
  endtask

  task automatic push_cycle(input int r, input bit chk, input bit frame);
    cyc_row.push_back(r);
    cyc_chk.push_back(chk);
    cyc_frame.push_back(frame);
  endtask

  task automatic expand_cycles();
    int prev_mode;
    int last;
    prev_mode = -1;
    for (int r = 0; r < row_name.size(); r++) begin
      if (int'(row_mimo[r]) != prev_mode) begin
        // frame keeps alternating while the new mode settles
        for (int j = 0; j < settle_cycles; j++) begin
          push_cycle(r, 1'b0, row_frame[r] ^ ((settle_cycles - j) % 2 == 1));
        end
      end
      push_cycle(r, 1'b1, row_frame[r]);
      prev_mode = int'(row_mimo[r]);
    end
    last = row_name.size() - 1;
    for (int j = 0; j < tail_cycles; j++) begin
      push_cycle(last, 1'b0, row_frame[last] ^ (j % 2 == 0));
    end
  endtask

  task automatic drive_rise(input int n);
    int r;
    r = cyc_row[n];
    mimo_i    <= row_mimo[r];
    rx_data_i <= row_i[r];  // captured at the coming negedge
    tx_i0_i   <= row_i0[r];
    tx_q0_i   <= row_q0[r];
    tx_i1_i   <= row_i1[r];
    tx_q1_i   <= row_q1[r];
  endtask

  // rising word and frame go out half a cycle before their capture edge
  task automatic drive_fall(input int n);
    rx_data_i  <= row_q[cyc_row[n]];
    rx_frame_i <= cyc_frame[n];
  endtask

  // advance the model by one rising edge
  task automatic model_step(input int n);
    bit                    sync;
    bit                    use_ch0;
    bit                    fr_p;
    int                    r;
    radio_io_pkg::sample_t in_i0;
    radio_io_pkg::sample_t in_q0;
    radio_io_pkg::sample_t in_i1;
    radio_io_pkg::sample_t in_q1;
    radio_io_pkg::sample_t pq;
    radio_io_pkg::sample_t pi;
    sync  = mode_seen(n);
    in_i0 = '0;
    in_q0 = '0;
    in_i1 = '0;
    in_q1 = '0;
    if (n >= 1) begin
      r     = cyc_row[n-1];
      in_i0 = row_i0[r];
      in_q0 = row_q0[r];
      in_i1 = row_i1[r];
      in_q1 = row_q1[r];
    end
    exp_di_rise = exp_fi;  // launch takes the framer word before it moves
    exp_dq_fall = exp_fq;
    exp_fr_rise = exp_ffr;
    exp_fr_fall = exp_ffr & sync;
    if (sync) begin
      use_ch0    = exp_stb_tx;
      exp_ffr    = exp_stb_tx;
      exp_stb_tx = ~exp_stb_tx;
    end else begin
      use_ch0    = (in_i0 != 0) || (in_q0 != 0);
      exp_ffr    = 1'b1;
      exp_stb_tx = 1'b1;
    end
    exp_fi = use_ch0 ? in_i0 : in_i1;
    exp_fq = use_ch0 ? in_q0 : in_q1;
    fr_p = 1'b0;
    pq   = 'x;
    pi   = 'x;
    if (n >= 2) begin
      r    = cyc_row[n-2];
      fr_p = cyc_frame[n-2];
      pq   = row_q[r];
      pi   = row_i[r];
    end
    if (!sync) begin
      exp_stb_rx = 1'b1;
      exp_i0 = pi;
      exp_q0 = pq;
      exp_i1 = pi;
      exp_q1 = pq;
    end else if (fr_p) begin
      exp_stb_rx = 1'b0;
      exp_i0 = pi;
      exp_q0 = pq;
    end else begin
      exp_stb_rx = 1'b1;  // channel 1 closes the pair
      exp_i1 = pi;
      exp_q1 = pq;
    end
  endtask

  task automatic check_val(input string test, input string sig,
                           input logic [11:0] exp_v, input logic [11:0] act_v, input int cat);
    assert (act_v === exp_v)
    else begin
      $display("ERR %s %s expected %h actual %h", test, sig, exp_v, act_v);
      err_cnt[cat] = err_cnt[cat] + 1;
    end
  endtask

  task automatic check_quiet();
    check_val("reset", "rx_stb_o", 12'd0, rx_stb_o, cat_ctl);
    check_val("reset", "tx_stb_o", 12'd0, tx_stb_o, cat_ctl);
    check_val("reset", "tx_frame_o", 12'd0, tx_frame_o, cat_ctl);
    check_val("reset", "tx_clk_o", 12'd0, tx_clk_o, cat_ctl);
  endtask

  task automatic check_rise(input int n);
    string test;
    test = "startup";
    if (n >= 2) begin
      test = row_name[cyc_row[n-2]];
    end
    check_val(test, "tx_clk_o rise", 12'd1, tx_clk_o, cat_ctl);
    check_val(test, "tx_stb_o", exp_stb_tx, tx_stb_o, cat_tx);
    check_val(test, "tx_frame_o rise", exp_fr_rise, tx_frame_o, cat_tx);
    check_val(test, "rx_stb_o", exp_stb_rx, rx_stb_o, cat_rx);
    if (n >= 2 && cyc_chk[n-2]) begin
      check_val(test, "tx_data_o rise", exp_di_rise, tx_data_o, cat_tx);
      check_val(test, "rx_i0_o", exp_i0, rx_i0_o, cat_rx);
      check_val(test, "rx_q0_o", exp_q0, rx_q0_o, cat_rx);
      check_val(test, "rx_i1_o", exp_i1, rx_i1_o, cat_rx);
      check_val(test, "rx_q1_o", exp_q1, rx_q1_o, cat_rx);
    end
  endtask

  task automatic check_fall(input int n);
    string test;
    test = "startup";
    if (n >= 2) begin
      test = row_name[cyc_row[n-2]];
    end
    check_val(test, "tx_clk_o fall", 12'd0, tx_clk_o, cat_ctl);
    check_val(test, "tx_frame_o fall", exp_fr_fall, tx_frame_o, cat_tx);
    if (n >= 2 && cyc_chk[n-2]) begin
      check_val(test, "tx_data_o fall", exp_dq_fall, tx_data_o, cat_tx);
    end
  endtask

  initial begin
    radio_clk  = 1'b0;
    radio_rst  = 1'b1;
    mimo_i     = 1'b0;
    rx_data_i  = '0;
    rx_frame_i = 1'b0;
    tx_i0_i    = '0;
    tx_q0_i    = '0;
    tx_i1_i    = '0;
    tx_q1_i    = '0;
    fill_table();
    expand_cycles();
    cycle_limit = row_name.size() * 8 + rst_cycles + 50;
    repeat (rst_cycles) begin
      @(posedge radio_clk);
      #1;
      check_quiet();
      @(negedge radio_clk);
      #1;
      check_quiet();
    end
    @(posedge radio_clk);
    radio_rst <= 1'b0;
    @(negedge radio_clk);
    drive_fall(0);
    #1;
    check_quiet();  // first running edge is still ahead
    for (int n = 0; n < cyc_row.size(); n++) begin
      @(posedge radio_clk);
      drive_rise(n);
      model_step(n);
      #1;
      check_rise(n);
      @(negedge radio_clk);
      if (n + 1 < cyc_row.size()) begin
        drive_fall(n + 1);
      end
      #1;
      check_fall(n);
    end
    $display("rx errors %0d, tx errors %0d, clock and reset errors %0d",
             err_cnt[cat_rx], err_cnt[cat_tx], err_cnt[cat_ctl]);
    if (err_cnt[cat_rx] + err_cnt[cat_tx] + err_cnt[cat_ctl] == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : radio_io_tb

`default_nettype wire

/* design/ddr_capture.sv */
// ==================================================
// ddr capture
// samples rx data and frame on both clock edges
// and presents each pair on the next rising edge
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module ddr_capture (
  input  wire                    radio_clk,
  input  wire                    radio_rst,
  input  wire radio_io_pkg::sample_t rx_data_i,
  input  wire                    rx_frame_i,
  output radio_io_pkg::sample_t  rise_data_o,
  output radio_io_pkg::sample_t  fall_data_o,
  output logic                   frame_rise_o,
  output logic                   frame_fall_o
);

  radio_io_pkg::sample_t rise_q; // rising half word (Q)
  radio_io_pkg::sample_t fall_q; // falling half word (I)
  logic                  frame_rise_q;
  logic                  frame_fall_q;

  // first stage, rising half
  always_ff @(posedge radio_clk) begin
    rise_q <= rx_data_i;
  end

  // first stage, falling half
  always_ff @(negedge radio_clk) begin
    fall_q <= rx_data_i;
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      frame_rise_q <= 1'b0;
    end else begin
      frame_rise_q <= rx_frame_i;
    end
  end

  always_ff @(negedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      frame_fall_q <= 1'b0;
    end else begin
      frame_fall_q <= rx_frame_i;
    end
  end

  // same-edge retiming, both halves appear together
  always_ff @(posedge radio_clk) begin
    rise_data_o <= rise_q;
    fall_data_o <= fall_q;
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      frame_rise_o <= 1'b0;
      frame_fall_o <= 1'b0;
    end else begin
      frame_rise_o <= frame_rise_q;
      frame_fall_o <= frame_fall_q;
    end
  end

endmodule : ddr_capture

`default_nettype wire

/* design/ddr_launch.sv */
// ==================================================
// ddr launch
// output DDR registers for tx data, frame and the
// forwarded tx clock
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module ddr_launch (
  input  wire                        radio_clk,
  input  wire                        radio_rst,
  input  wire                        mimo_sync_i,
  input  wire radio_io_pkg::sample_t tx_i_i,
  input  wire radio_io_pkg::sample_t tx_q_i,
  input  wire                        tx_frame_i,
  output radio_io_pkg::sample_t      tx_data_o,
  output logic                       tx_frame_o,
  output logic                       tx_clk_o
);

  radio_io_pkg::iq_pair_t data_pair; // {D1 = I, D2 = Q}
  logic [1:0]             frame_pair;
  logic [1:0]             clk_pair;

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      data_pair  <= '0;
      frame_pair <= 2'b00;
      clk_pair   <= 2'b00; // keeps the forwarded clock quiet
    end else begin
      data_pair  <= {tx_i_i, tx_q_i};
      // SISO frame drops in the falling half
      frame_pair <= {tx_frame_i, tx_frame_i & mimo_sync_i};
      clk_pair   <= 2'b10;
    end
  end

  // clock phase picks D1 in the rising half, D2 in the falling half
  always_comb begin
    if (radio_clk) begin
      tx_data_o  = data_pair[radio_io_pkg::sample_w +: radio_io_pkg::sample_w];
      tx_frame_o = frame_pair[1];
      tx_clk_o   = clk_pair[1];
    end else begin
      tx_data_o  = data_pair[0 +: radio_io_pkg::sample_w];
      tx_frame_o = frame_pair[0];
      tx_clk_o   = clk_pair[0];
    end
  end

endmodule : ddr_launch

`default_nettype wire

/* design/radio_io_pkg.sv */
// ==================================================
// radio io package
// sample widths, sample typedefs and fixed words
// shared by the AD9361-class DDR interface
// ==================================================
`default_nettype none

package radio_io_pkg;

  // one I or Q sample, also the DDR bus width
  localparam int sample_w = 12;

  // flops in the mimo level synchronizer
  localparam int sync_stages = 2;

  typedef logic [sample_w-1:0]   sample_t;  // single I or Q word
  typedef logic [2*sample_w-1:0] iq_pair_t; // {I, Q}

  // empty I/Q pair, an idle channel in SISO mode
  localparam iq_pair_t iq_zero = '0;

endpackage : radio_io_pkg

`default_nettype wire

/* design/radio_io_top.sv */
// ==================================================
// radio io top
// baseband side of the 12-bit DDR transceiver link,
// rx capture and deframe, tx frame and launch
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module radio_io_top (
  input  wire                        radio_clk,
  input  wire                        radio_rst,
  input  wire                        mimo_i,
  // transceiver receive bus
  input  wire radio_io_pkg::sample_t rx_data_i,
  input  wire                        rx_frame_i,
  // receive samples
  output radio_io_pkg::sample_t      rx_i0_o,
  output radio_io_pkg::sample_t      rx_q0_o,
  output radio_io_pkg::sample_t      rx_i1_o,
  output radio_io_pkg::sample_t      rx_q1_o,
  output logic                       rx_stb_o,
  // transmit samples
  input  wire radio_io_pkg::sample_t tx_i0_i,
  input  wire radio_io_pkg::sample_t tx_q0_i,
  input  wire radio_io_pkg::sample_t tx_i1_i,
  input  wire radio_io_pkg::sample_t tx_q1_i,
  output logic                       tx_stb_o,
  // transceiver transmit bus
  output radio_io_pkg::sample_t      tx_data_o,
  output logic                       tx_frame_o,
  output logic                       tx_clk_o
);

  radio_io_pkg::sample_t rise_data;
  radio_io_pkg::sample_t fall_data;
  logic                  frame_rise;
  logic                  frame_fall;
  logic                  mimo_sync; // shared by rx and tx halves

  radio_io_pkg::sample_t tx_i;
  radio_io_pkg::sample_t tx_q;
  logic                  tx_frame_int;

  ddr_capture u_capture (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .rx_data_i    (rx_data_i),
    .rx_frame_i   (rx_frame_i),
    .rise_data_o  (rise_data),
    .fall_data_o  (fall_data),
    .frame_rise_o (frame_rise),
    .frame_fall_o (frame_fall)
  );

  rx_deframer u_deframer (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .mimo_i       (mimo_i),
    .rise_data_i  (rise_data),
    .fall_data_i  (fall_data),
    .frame_rise_i (frame_rise),
    .frame_fall_i (frame_fall),
    .mimo_sync_o  (mimo_sync),
    .rx_i0_o      (rx_i0_o),
    .rx_q0_o      (rx_q0_o),
    .rx_i1_o      (rx_i1_o),
    .rx_q1_o      (rx_q1_o),
    .rx_stb_o     (rx_stb_o)
  );

  tx_framer u_framer (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .mimo_sync_i (mimo_sync),
    .tx_i0_i     (tx_i0_i),
    .tx_q0_i     (tx_q0_i),
    .tx_i1_i     (tx_i1_i),
    .tx_q1_i     (tx_q1_i),
    .tx_stb_o    (tx_stb_o),
    .tx_i_o      (tx_i),
    .tx_q_o      (tx_q),
    .tx_frame_o  (tx_frame_int)
  );

  ddr_launch u_launch (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .mimo_sync_i (mimo_sync),
    .tx_i_i      (tx_i),
    .tx_q_i      (tx_q),
    .tx_frame_i  (tx_frame_int),
    .tx_data_o   (tx_data_o),
    .tx_frame_o  (tx_frame_o),
    .tx_clk_o    (tx_clk_o)
  );

endmodule : radio_io_top

`default_nettype wire

/* design/rx_deframer.sv */
// ==================================================
// rx deframer
// synchronizes the mimo level and sorts captured
// word pairs into channel I/Q with a strobe
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module rx_deframer (
  input  wire                        radio_clk,
  input  wire                        radio_rst,
  input  wire                        mimo_i,
  input  wire radio_io_pkg::sample_t rise_data_i,
  input  wire radio_io_pkg::sample_t fall_data_i,
  input  wire                        frame_rise_i,
  input  wire                        frame_fall_i,
  output logic                       mimo_sync_o,
  output radio_io_pkg::sample_t      rx_i0_o,
  output radio_io_pkg::sample_t      rx_q0_o,
  output radio_io_pkg::sample_t      rx_i1_o,
  output radio_io_pkg::sample_t      rx_q1_o,
  output logic                       rx_stb_o
);

  logic [radio_io_pkg::sync_stages-1:0] mimo_meta;

  // mimo level synchronizer, comes up in SISO
  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      mimo_meta <= '0;
    end else begin
      mimo_meta <= {mimo_meta[radio_io_pkg::sync_stages-2:0], mimo_i};
    end
  end

  assign mimo_sync_o = mimo_meta[radio_io_pkg::sync_stages-1];

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      rx_stb_o <= 1'b0;
    end else if (mimo_sync_o) begin
      rx_stb_o <= ~frame_rise_i; // fires with the channel 1 update
    end else begin
      rx_stb_o <= 1'b1;
    end
  end

  // channel demux, rising word is Q and falling word is I
  always_ff @(posedge radio_clk) begin
    if (mimo_sync_o) begin
      if (frame_rise_i) begin
        rx_i0_o <= fall_data_i;
        rx_q0_o <= rise_data_i;
      end else begin
        rx_i1_o <= fall_data_i;
        rx_q1_o <= rise_data_i;
      end
    end else begin
      rx_i0_o <= fall_data_i; // SISO copies the pair to both channels
      rx_q0_o <= rise_data_i;
      rx_i1_o <= fall_data_i;
      rx_q1_o <= rise_data_i;
    end
  end

  // once MIMO has settled through the capture pipe, the frame line
  // holds for a whole clock and flips between channel 0 and 1
  a_frame_halves: assert property (@(posedge radio_clk) disable iff (radio_rst)
    (mimo_sync_o && $past(mimo_sync_o) && $past(mimo_sync_o, 2))
      |-> (frame_rise_i == frame_fall_i))
    else $error("rx frame differs between halves in MIMO mode");

  a_frame_alternates: assert property (@(posedge radio_clk) disable iff (radio_rst)
    (mimo_sync_o && $past(mimo_sync_o) && $past(mimo_sync_o, 2))
      |-> (frame_rise_i != $past(frame_rise_i)))
    else $error("rx frame did not alternate in MIMO mode");

endmodule : rx_deframer

`default_nettype wire

/* design/tx_framer.sv */
// ==================================================
// tx framer
// interleaves channel 0/1 samples in MIMO mode or
// picks the active channel in SISO mode
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module tx_framer (
  input  wire                        radio_clk,
  input  wire                        radio_rst,
  input  wire                        mimo_sync_i,
  input  wire radio_io_pkg::sample_t tx_i0_i,
  input  wire radio_io_pkg::sample_t tx_q0_i,
  input  wire radio_io_pkg::sample_t tx_i1_i,
  input  wire radio_io_pkg::sample_t tx_q1_i,
  output logic                       tx_stb_o,
  output radio_io_pkg::sample_t      tx_i_o,
  output radio_io_pkg::sample_t      tx_q_o,
  output logic                       tx_frame_o
);

  radio_io_pkg::iq_pair_t ch0_pair;
  logic                   use_ch0;

  assign ch0_pair = {tx_i0_i, tx_q0_i};

  // channel 0 on strobe-high cycles in MIMO,
  // otherwise whenever it carries anything
  always_comb begin
    if (mimo_sync_i) begin
      use_ch0 = tx_stb_o;
    end else begin
      use_ch0 = (ch0_pair != radio_io_pkg::iq_zero);
    end
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      tx_stb_o   <= 1'b0;
      tx_frame_o <= 1'b0;
    end else if (mimo_sync_i) begin
      tx_stb_o   <= ~tx_stb_o;
      tx_frame_o <= tx_stb_o; // frame high marks channel 0
    end else begin
      tx_stb_o   <= 1'b1;
      tx_frame_o <= 1'b1;
    end
  end

  always_ff @(posedge radio_clk) begin
    if (use_ch0) begin
      tx_i_o <= tx_i0_i;
      tx_q_o <= tx_q0_i;
    end else begin
      tx_i_o <= tx_i1_i;
      tx_q_o <= tx_q1_i;
    end
  end

endmodule : tx_framer

`default_nettype wire

/* sources.f */
design/radio_io_pkg.sv
design/ddr_capture.sv
design/rx_deframer.sv
design/tx_framer.sv
design/ddr_launch.sv
design/radio_io_top.sv
bench/radio_io_tb.sv
